// ==== hub75_defs.svh ====
`ifndef HUB75_DEFS_SVH
`define HUB75_DEFS_SVH

// panel geometry
`define HUB75_PIX_PER_LINE 64   // pixels per half, per plane
`define HUB75_SCAN_RATE 32      // scan addresses on the panel

// index and address widths
`define HUB75_PIX_IDX_W ($clog2(`HUB75_PIX_PER_LINE))
`define HUB75_ADDR_W ($clog2(`HUB75_SCAN_RATE))

// colour depth
`define HUB75_COLOR_BITS 3      // also the number of bit planes
`define HUB75_PIXEL_BITS (3 * `HUB75_COLOR_BITS)
`define HUB75_PLANE_W ($clog2(`HUB75_COLOR_BITS))

// display time of plane 0 in clk_in cycles
// plane p is shown for this unit shifted left by p
`define HUB75_BCM_UNIT 10

`endif

// ==== hub75_pkg.sv ====
`include "hub75_defs.svh"

package hub75_pkg;

   // one pixel word
   // stored and built as a raw word, read back by colour
   typedef union packed {
      logic [`HUB75_PIXEL_BITS-1:0] raw;
      struct packed {
         logic [`HUB75_COLOR_BITS-1:0] blue;    // bits 8:6
         logic [`HUB75_COLOR_BITS-1:0] green;   // bits 5:3
         logic [`HUB75_COLOR_BITS-1:0] red;     // bits 2:0
      } color;
   } hub75_pixel_u;

endpackage

// ==== column_buffer.sv ====
`timescale 1ns/1ps
`include "hub75_defs.svh"

module column_buffer
   import hub75_pkg::*;
(
   input  logic clk_in,
   input  logic load,
   input  logic [1:0][`HUB75_PIX_PER_LINE-1:0][`HUB75_PIXEL_BITS-1:0] column_data,
   input  logic [`HUB75_PIX_IDX_W-1:0] pix_idx,
   output hub75_pixel_u pix_upper,
   output hub75_pixel_u pix_lower
);

   localparam int HALF_UPPER = 0;   // column_data[0] drives rgb0
   localparam int HALF_LOWER = 1;

   // line storage, both halves
   // lets the source set up the next line during display
   hub75_pixel_u upper_mem [`HUB75_PIX_PER_LINE];
   hub75_pixel_u lower_mem [`HUB75_PIX_PER_LINE];

   always_ff @(posedge clk_in) begin
      if (load) begin
         for (int i = 0; i < `HUB75_PIX_PER_LINE; i++) begin
            upper_mem[i].raw <= column_data[HALF_UPPER][i];
            lower_mem[i].raw <= column_data[HALF_LOWER][i];
         end
      end
   end

   // pixel pair for the current shift position
   assign pix_upper = upper_mem[pix_idx];
   assign pix_lower = lower_mem[pix_idx];

endmodule

// ==== bitplane_mux.sv ====
`timescale 1ns/1ps
`include "hub75_defs.svh"

module bitplane_mux
   import hub75_pkg::*;
(
   input  logic clk_in,
   input  logic rst_in,
   input  logic shift_step,
   input  logic [`HUB75_PLANE_W-1:0] plane,
   input  hub75_pixel_u pix_upper,
   input  hub75_pixel_u pix_lower,
   output logic [2:0] rgb0,
   output logic [2:0] rgb1
);

   // one plane bit per colour
   // panel order is {b, g, r}
   function automatic logic [2:0] plane_bits(input hub75_pixel_u pix,
                                             input logic [`HUB75_PLANE_W-1:0] sel);
      logic [2:0] bits;
      bits[0] = pix.color.red[sel];
      bits[1] = pix.color.green[sel];
      bits[2] = pix.color.blue[sel];
      return bits;
   endfunction

   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         rgb0 <= 3'b000;
         rgb1 <= 3'b000;
      end else if (shift_step) begin   // first half of each pixel pair
         rgb0 <= plane_bits(pix_upper, plane);
         rgb1 <= plane_bits(pix_lower, plane);
      end
   end

endmodule

// ==== bcm_timer.sv ====
`timescale 1ns/1ps
`include "hub75_defs.svh"

module bcm_timer (
   input  logic clk_in,
   input  logic rst_in,
   input  logic bcm_start,
   input  logic [`HUB75_PLANE_W-1:0] plane,
   output logic bcm_done
);

   // longest display time is that of the top plane
   localparam int MAX_TICKS = `HUB75_BCM_UNIT << (`HUB75_COLOR_BITS - 1);
   localparam int CNT_W = $clog2(MAX_TICKS + 1);

   logic [CNT_W-1:0] count;   // zero when idle

   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         count <= '0;
      end else if (bcm_start) begin
         count <= CNT_W'(`HUB75_BCM_UNIT) << plane;   // binary weight
      end else if (count != '0) begin
         count <= count - CNT_W'(1);
      end
   end

   // last display cycle of the plane
   // count sits at 1 for a single cycle, then holds at zero
   assign bcm_done = (count == CNT_W'(1));

endmodule

// ==== hub75_scan_ctrl.sv ====
`timescale 1ns/1ps
`include "hub75_defs.svh"

module hub75_scan_ctrl (
   input  logic clk_in,
   input  logic rst_in,
   input  logic tvalid,
   input  logic [`HUB75_ADDR_W-1:0] address_data,
   input  logic bcm_done,
   output logic tready,
   output logic load,
   output logic [`HUB75_PIX_IDX_W-1:0] pix_idx,
   output logic [`HUB75_PLANE_W-1:0] plane,
   output logic shift_step,
   output logic bcm_start,
   output logic led_clk,
   output logic led_latch,
   output logic led_oe_n,
   output logic [`HUB75_ADDR_W-1:0] hub75_address
);

   localparam logic [1:0] ST_IDLE    = 2'd0;
   localparam logic [1:0] ST_SHIFT   = 2'd1;
   localparam logic [1:0] ST_LATCH   = 2'd2;
   localparam logic [1:0] ST_DISPLAY = 2'd3;

   localparam logic [`HUB75_PIX_IDX_W-1:0] LAST_PIX =
      `HUB75_PIX_IDX_W'(`HUB75_PIX_PER_LINE - 1);
   localparam logic [`HUB75_PLANE_W-1:0] LAST_PLANE =
      `HUB75_PLANE_W'(`HUB75_COLOR_BITS - 1);

   logic [1:0] state;
   logic phase;   // 0 = data step, 1 = led_clk high

   // handshake, one line at a time
   assign tready = (state == ST_IDLE);
   assign load   = tvalid && tready;

   assign shift_step = (state == ST_SHIFT) && !phase;
   assign bcm_start  = (state == ST_LATCH);   // plane is stable here

   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         state         <= ST_IDLE;
         phase         <= 1'b0;
         pix_idx       <= '0;
         plane         <= '0;
         led_clk       <= 1'b0;
         led_latch     <= 1'b0;
         led_oe_n      <= 1'b1;   // panel dark
         hub75_address <= '0;
      end else begin
         led_clk   <= shift_step;   // rises one cycle after each data step
         led_latch <= 1'b0;

         case (state)
            ST_IDLE: begin
               if (load) begin
                  state         <= ST_SHIFT;
                  hub75_address <= address_data;   // held for the whole line
                  phase         <= 1'b0;
                  pix_idx       <= '0;
                  plane         <= '0;
               end
            end

            ST_SHIFT: begin
               phase <= ~phase;
               if (phase) begin
                  pix_idx <= pix_idx + `HUB75_PIX_IDX_W'(1);   // wraps to 0 after last
                  if (pix_idx == LAST_PIX) begin
                     state     <= ST_LATCH;
                     led_latch <= 1'b1;
                  end
               end
            end

            ST_LATCH: begin
               state    <= ST_DISPLAY;
               led_oe_n <= 1'b0;
            end

            ST_DISPLAY: begin
               if (bcm_done) begin
                  led_oe_n <= 1'b1;
                  phase    <= 1'b0;
                  if (plane == LAST_PLANE) begin
                     state <= ST_IDLE;   // line finished
                  end else begin
                     plane <= plane + `HUB75_PLANE_W'(1);
                     state <= ST_SHIFT;
                  end
               end
            end

            default: state <= ST_IDLE;
         endcase
      end
   end

endmodule

// ==== hub75_output.sv ====
`timescale 1ns/1ps
`include "hub75_defs.svh"

module hub75_output
   import hub75_pkg::*;
(
   input  logic clk_in,
   input  logic rst_in,
   input  logic tvalid,
   input  logic [1:0][`HUB75_PIX_PER_LINE-1:0][`HUB75_PIXEL_BITS-1:0] column_data,
   input  logic [`HUB75_ADDR_W-1:0] address_data,
   output logic tready,
   output logic [2:0] rgb0,
   output logic [2:0] rgb1,
   output logic led_clk,
   output logic led_latch,
   output logic led_oe_n,
   output logic [`HUB75_ADDR_W-1:0] hub75_address
);

   logic load;
   logic shift_step;
   logic bcm_start;
   logic bcm_done;
   logic [`HUB75_PIX_IDX_W-1:0] pix_idx;
   logic [`HUB75_PLANE_W-1:0] plane;
   hub75_pixel_u pix_upper;
   hub75_pixel_u pix_lower;

   hub75_scan_ctrl hub75_scan_ctrl_i (
      .clk_in(clk_in), .rst_in(rst_in),
      .tvalid(tvalid), .address_data(address_data), .bcm_done(bcm_done),
      .tready(tready), .load(load), .pix_idx(pix_idx), .plane(plane),
      .shift_step(shift_step), .bcm_start(bcm_start),
      .led_clk(led_clk), .led_latch(led_latch), .led_oe_n(led_oe_n),
      .hub75_address(hub75_address)
   );

   column_buffer column_buffer_i (
      .clk_in(clk_in), .load(load), .column_data(column_data),
      .pix_idx(pix_idx), .pix_upper(pix_upper), .pix_lower(pix_lower)
   );

   bitplane_mux bitplane_mux_i (
      .clk_in(clk_in), .rst_in(rst_in), .shift_step(shift_step),
      .plane(plane), .pix_upper(pix_upper), .pix_lower(pix_lower),
      .rgb0(rgb0), .rgb1(rgb1)
   );

   bcm_timer bcm_timer_i (
      .clk_in(clk_in), .rst_in(rst_in), .bcm_start(bcm_start),
      .plane(plane), .bcm_done(bcm_done)
   );

endmodule

// ==== tb_hub75_output.sv ====
`timescale 1ns/1ps
`include "hub75_defs.svh"

module tb_hub75_output;

   localparam int NUM_LINES      = 5;
   localparam int PIX            = `HUB75_PIX_PER_LINE;
   localparam int PLANES         = `HUB75_COLOR_BITS;
   localparam int RESET_CYCLES   = 8;
   localparam int IDLE_GAP       = 3;      // idle cycles before a non-held line
   localparam int ACCEPT_TIMEOUT = 4000;   // longer than one full line
   localparam int READY_TIMEOUT  = 4000;
   localparam int DONE_TIMEOUT   = 4000;

   // scan address and tvalid hold flag per line
   localparam logic [`HUB75_ADDR_W-1:0] TBL_ADDR [NUM_LINES] =
      '{5'd3, 5'd17, 5'd31, 5'd0, 5'd12};
   localparam bit TBL_HOLD [NUM_LINES] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1};

   logic clk_in = 1'b0;
   logic rst_in;
   logic tvalid;
   logic [1:0][PIX-1:0][`HUB75_PIXEL_BITS-1:0] column_data;
   logic [`HUB75_ADDR_W-1:0] address_data;
   logic tready;
   logic [2:0] rgb0;
   logic [2:0] rgb1;
   logic led_clk;
   logic led_latch;
   logic led_oe_n;
   logic [`HUB75_ADDR_W-1:0] hub75_address;

   logic [`HUB75_PIXEL_BITS-1:0] line_pix [NUM_LINES][2][PIX];   // [line][half][pixel]
   logic [31:0] lcg_state = 32'h447c;

   // panel model and line bookkeeping of the monitor
   logic [2:0] model0 [PIX];
   logic [2:0] model1 [PIX];
   logic prev_clk;
   logic prev_latch;
   logic prev_oe_n;
   bit line_active;
   int cur_line;
   int acc_count;
   int lines_done;
   int stall_cycles;
   int rises;
   int oe_cycles;
   int latches_in_line;

   always #4 clk_in = ~clk_in;

   hub75_output hub75_output_i (
      .clk_in(clk_in), .rst_in(rst_in), .tvalid(tvalid),
      .column_data(column_data), .address_data(address_data),
      .tready(tready), .rgb0(rgb0), .rgb1(rgb1),
      .led_clk(led_clk), .led_latch(led_latch), .led_oe_n(led_oe_n),
      .hub75_address(hub75_address)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // bit p of each colour as {blue, green, red}
   // red sits in bits 2:0, green in 5:3 and blue in 8:6
   function automatic logic [2:0] exp_bits(input logic [`HUB75_PIXEL_BITS-1:0] w, input int p);
      return {w[6 + p], w[3 + p], w[p]};
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
         $display("** FAIL **");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic report_error(input string what);
      $display("%s", what);
      $display("** FAIL **");
      $fatal(1, "simulation stopped");
   endtask

   task automatic fill_lines();
      for (int i = 0; i < NUM_LINES; i++) begin
         for (int h = 0; h < 2; h++) begin
            for (int k = 0; k < PIX; k++) begin
               lcg_state = lcg_next(lcg_state);
               line_pix[i][h][k] = lcg_state[24:16];   // upper bits are less regular
            end
         end
      end
   endtask

   task automatic present_line(input int idx);
      logic [1:0][PIX-1:0][`HUB75_PIXEL_BITS-1:0] word;
      for (int h = 0; h < 2; h++) begin
         for (int k = 0; k < PIX; k++) begin
            word[h][k] = line_pix[idx][h][k];
         end
      end
      tvalid       <= 1'b1;
      column_data  <= word;
      address_data <= TBL_ADDR[idx];
   endtask

   task automatic wait_accept(input int idx);
      int cycles;
      bit done;
      cycles = 0;
      done = 1'b0;
      while (!done) begin
         @(posedge clk_in);
         if (tvalid && tready) begin
            done = 1'b1;
         end else begin
            cycles++;
            if (cycles > ACCEPT_TIMEOUT)
               report_error($sformatf("line %0d was never accepted by the driver", idx));
         end
      end
   endtask

   task automatic wait_ready();
      int cycles;
      cycles = 0;
      @(posedge clk_in);
      while (!tready) begin
         cycles++;
         if (cycles > READY_TIMEOUT)
            report_error("tready did not come back after a line");
         @(posedge clk_in);
      end
   endtask

   task automatic wait_lines_done();
      int cycles;
      cycles = 0;
      @(negedge clk_in);   // away from the edge the monitor updates on
      while (lines_done < NUM_LINES) begin
         cycles++;
         if (cycles > DONE_TIMEOUT)
            report_error("the last line never finished its display");
         @(negedge clk_in);
      end
   endtask

   // panel monitor sampling on the system clock edge
   always @(posedge clk_in) begin
      if (rst_in) begin
         prev_clk = 1'b0;
         prev_latch = 1'b0;
         prev_oe_n = 1'b1;
         line_active = 1'b0;
      end else begin
         if (tvalid && !tready)
            stall_cycles++;
         if (line_active)
            check_val("hub75_address", 32'(hub75_address), 32'(TBL_ADDR[cur_line]));
         if (led_clk && !led_oe_n)
            report_error("panel was lit while led_clk was high");
         if (!led_oe_n && (!line_active || latches_in_line == 0))
            report_error("led_oe_n went low before any latch of the line");

         if (led_clk && !prev_clk) begin   // rising shift clock
            for (int j = PIX - 1; j > 0; j--) begin
               model0[j] = model0[j - 1];
               model1[j] = model1[j - 1];
            end
            model0[0] = rgb0;
            model1[0] = rgb1;
            rises++;
         end

         if (led_latch) begin
            if (prev_latch)
               report_error("led_latch stayed high for more than one cycle");
            if (!line_active || latches_in_line >= PLANES)
               report_error("unexpected latch outside the three planes of a line");
            check_val("led_clk", 32'(led_clk), 32'd0);
            check_val("led_clk rises", 32'(rises), 32'(PIX));
            // pixel 0 went in first and sits at the far end
            for (int k = 0; k < PIX; k++) begin
               check_val($sformatf("rgb0 pixel %0d plane %0d", k, latches_in_line),
                         32'(model0[PIX - 1 - k]),
                         32'(exp_bits(line_pix[cur_line][0][k], latches_in_line)));
               check_val($sformatf("rgb1 pixel %0d plane %0d", k, latches_in_line),
                         32'(model1[PIX - 1 - k]),
                         32'(exp_bits(line_pix[cur_line][1][k], latches_in_line)));
            end
            rises = 0;
            oe_cycles = 0;
            latches_in_line++;
         end

         if (!led_oe_n)
            oe_cycles++;

         if (led_oe_n && !prev_oe_n) begin   // end of a plane's display
            check_val($sformatf("led_oe_n low cycles plane %0d", latches_in_line - 1),
                      32'(oe_cycles), 32'(`HUB75_BCM_UNIT << (latches_in_line - 1)));
            if (latches_in_line == PLANES) begin
               line_active = 1'b0;
               lines_done++;
            end
         end

         if (line_active && tready)
            report_error("tready was high while a line was still on the panel");

         if (tvalid && tready) begin
            if (acc_count >= NUM_LINES)
               report_error("more lines were accepted than the table holds");
            cur_line = acc_count;
            acc_count++;
            line_active = 1'b1;
            latches_in_line = 0;
            rises = 0;
         end

         prev_clk = led_clk;
         prev_latch = led_latch;
         prev_oe_n = led_oe_n;
      end
   end

   initial begin
      rst_in = 1'b1;
      tvalid = 1'b0;
      column_data = '0;
      address_data = '0;
      acc_count = 0;
      lines_done = 0;
      stall_cycles = 0;
      fill_lines();

      repeat (RESET_CYCLES) @(posedge clk_in);
      rst_in <= 1'b0;
      repeat (2) @(posedge clk_in);

      // idle state before any line
      check_val("tready", 32'(tready), 32'd1);
      check_val("led_clk", 32'(led_clk), 32'd0);
      check_val("led_latch", 32'(led_latch), 32'd0);
      check_val("led_oe_n", 32'(led_oe_n), 32'd1);
      check_val("rgb0", 32'(rgb0), 32'd0);
      check_val("rgb1", 32'(rgb1), 32'd0);
      check_val("hub75_address", 32'(hub75_address), 32'd0);

      for (int i = 0; i < NUM_LINES; i++) begin
         if (!TBL_HOLD[i]) begin
            tvalid <= 1'b0;
            wait_ready();
            repeat (IDLE_GAP) @(posedge clk_in);
         end
         present_line(i);   // held lines go out while the driver is busy
         wait_accept(i);
      end
      tvalid <= 1'b0;

      wait_lines_done();
      check_val("accepted lines", 32'(acc_count), 32'(NUM_LINES));
      if (stall_cycles == 0) begin
         report_error("tvalid was never held against a busy driver");
      end else begin
         $display("** PASS **");
         $finish;
      end
   end

endmodule

// ==== src.f ====
+incdir+.
hub75_pkg.sv
column_buffer.sv
bitplane_mux.sv
bcm_timer.sv
hub75_scan_ctrl.sv
hub75_output.sv
tb_hub75_output.sv

// ==== Makefile ====
# Verilator build and run of the HUB75 row driver testbench

VERILATOR ?= verilator
TOP       ?= tb_hub75_output
RTL_TOP   ?= hub75_output
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -j 0
LINTFLAGS ?= -Wall

RTL_SRCS := hub75_pkg.sv column_buffer.sv bitplane_mux.sv bcm_timer.sv \
            hub75_scan_ctrl.sv hub75_output.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the log decides the result, not the simulator exit code
run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -qF '** PASS **' $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) +incdir+. $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
